//--- Makefile
# Verilator build and run for the naval board subsystem

VERILATOR ?= verilator
TOP       ?= naval_tb
FILELIST  ?= naval.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(BUILD_DIR)

//--- bench/naval_tb.sv
`timescale 1ns/100ps

module naval_tb;
    import naval_pkg::*;

    localparam int max_cmds       = 64;
    localparam int done_limit     = 100;   // Cycles allowed for one done pulse
    localparam int cycles_per_cmd = 200;

    logic         clk;
    logic         rst;
    logic         place_strobe;
    board_sel_t   place_board;
    coord_t       place_row;
    coord_t       place_col;
    logic         place_vertical;
    ship_len_t    place_len;
    logic         place_busy;
    logic         place_done;
    logic         place_ok;
    logic [1:0]   ships_placed_0;
    logic [1:0]   ships_placed_1;
    logic         fire_strobe;
    board_sel_t   fire_board;
    coord_t       fire_row;
    coord_t       fire_col;
    logic         fire_busy;
    logic         fire_done;
    shot_result_e fire_result;
    hits_cnt_t    cells_left_0;
    hits_cnt_t    cells_left_1;
    logic         fleet_sunk_0;
    logic         fleet_sunk_1;

    // Commands as read from the data file
    byte cmd_op    [max_cmds];
    int  cmd_board [max_cmds];
    int  cmd_row   [max_cmds];
    int  cmd_col   [max_cmds];
    int  cmd_vert  [max_cmds];
    int  cmd_len   [max_cmds];
    int  cmd_exp   [max_cmds];              // place_ok, or shot result code
    int  cmd_left0 [max_cmds];
    int  cmd_left1 [max_cmds];
    int  num_cmds;
    bit  loaded;

    logic [1:0] exp_ships [2];              // Ships each board should hold by now
    logic       far_marked [10];            // Board 1 rows 3 and 4, already shot at
    integer     seed = 32'hca55f0ff;
    int         value_errors;
    int         timeout_errors;
    int         file_errors;

    naval_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;              // 4 ns period
    end

    task automatic check_ok(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %0t: %s place_ok is %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    task automatic check_result(input shot_result_e got, input shot_result_e exp,
                                input string what);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %0t: %s fire_result is %s, expected %s",
                     $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_cells(input hits_cnt_t got, input hits_cnt_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_sunk(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %0t: %s is %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    task automatic check_busy(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %0t: %s is %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    task automatic check_ships(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // Counters of both boards against the file, fleet_sunk from the ship count
    task automatic compare_counters(input int n, input string tag);
        check_ships(ships_placed_0, exp_ships[0], {tag, " ships_placed_0"});
        check_ships(ships_placed_1, exp_ships[1], {tag, " ships_placed_1"});
        check_cells(cells_left_0, hits_cnt_t'(cmd_left0[n]), {tag, " cells_left_0"});
        check_cells(cells_left_1, hits_cnt_t'(cmd_left1[n]), {tag, " cells_left_1"});
        check_sunk(fleet_sunk_0, (exp_ships[0] != 0) && (cmd_left0[n] == 0),
                   {tag, " fleet_sunk_0"});
        check_sunk(fleet_sunk_1, (exp_ships[1] != 0) && (cmd_left1[n] == 0),
                   {tag, " fleet_sunk_1"});
    endtask

    task automatic load_commands();
        int               fd;
        int               got;
        byte              op;
        logic [8*128-1:0] rest;
        fd = $fopen("bench/naval_testdata.txt", "r");
        if (fd == 0) begin
            file_errors++;
            $display("Could not open bench/naval_testdata.txt");
        end else begin
            while (!$feof(fd) && num_cmds < max_cmds) begin
                got = $fscanf(fd, " %c", op);
                if (got != 1) break;                    // Nothing but blanks left
                if (op == "#") begin
                    got = $fgets(rest, fd);             // Column notes
                end else begin
                    got = $fscanf(fd, "%d %d %d %d %d %d %d %d",
                                  cmd_board[num_cmds], cmd_row[num_cmds], cmd_col[num_cmds],
                                  cmd_vert[num_cmds], cmd_len[num_cmds], cmd_exp[num_cmds],
                                  cmd_left0[num_cmds], cmd_left1[num_cmds]);
                    if (got != 8) begin
                        file_errors++;
                        $display("Data line for command %0d has missing fields", num_cmds);
                    end else begin
                        cmd_op[num_cmds] = op;
                        num_cmds++;
                    end
                end
            end
            $fclose(fd);
            if (num_cmds == 0) begin
                file_errors++;
                $display("The data file holds no commands");
            end
        end
    endtask

    // Called 1 ns after an edge, returns 1 ns after the edge that shows done
    task automatic wait_place(output logic seen);
        seen = 1'b0;
        for (int i = 0; i < done_limit && !seen; i++) begin
            if (place_done) seen = 1'b1;
            else begin
                @(posedge clk);
                #1;
            end
        end
        if (!seen) begin
            timeout_errors++;
            $display("At %0t a placement never completed, place_done did not pulse", $time);
        end
    endtask

    task automatic wait_fire(output logic seen);
        seen = 1'b0;
        for (int i = 0; i < done_limit && !seen; i++) begin
            if (fire_done) seen = 1'b1;
            else begin
                @(posedge clk);
                #1;
            end
        end
        if (!seen) begin
            timeout_errors++;
            $display("At %0t a shot never completed, fire_done did not pulse", $time);
        end
    endtask

    // Board 1 rows 3 and 4 hold no ships in the data, so only miss or repeat
    task automatic fire_random();
        int           pick;
        shot_result_e exp;
        logic         seen;
        @(posedge clk);                     // One cycle late, first reads then collide
        #1;
        pick = $unsigned($random(seed)) % 10;
        exp  = far_marked[pick] ? shot_repeat : shot_miss;
        far_marked[pick] = 1'b1;
        fire_board  = 1'b1;
        fire_row    = coord_t'(3 + pick / 5);
        fire_col    = coord_t'(pick % 5);
        fire_strobe = 1'b1;
        @(posedge clk);
        #1;
        fire_strobe = 1'b0;
        check_busy(fire_busy, 1'b1, "background shot fire_busy");
        wait_fire(seen);
        if (seen) check_result(fire_result, exp, "background shot");
    endtask

    task automatic run_place(input int n);
        logic  seen;
        string tag;
        tag = $sformatf("command %0d place", n);
        fork
            begin
                place_board    = board_sel_t'(cmd_board[n]);
                place_row      = coord_t'(cmd_row[n]);
                place_col      = coord_t'(cmd_col[n]);
                place_vertical = cmd_vert[n][0];
                place_len      = ship_len_t'(cmd_len[n]);
                place_strobe   = 1'b1;
                @(posedge clk);
                #1;
                place_strobe = 1'b0;
                check_busy(place_busy, 1'b1, {tag, " place_busy"});
                wait_place(seen);
                if (cmd_exp[n] != 0) exp_ships[cmd_board[n]] = exp_ships[cmd_board[n]] + 2'd1;
                if (seen) begin
                    check_ok(place_ok, cmd_exp[n][0], tag);     // Valid with the done pulse
                    @(posedge clk);         // Resolver adds the ship one cycle after done
                    #1;
                    compare_counters(n, tag);
                    check_busy(place_busy, 1'b0, {tag, " place_busy"});
                end
            end
            fire_random();                  // Contends with the placer for the memory
        join
    endtask

    task automatic run_fire(input int n);
        logic  seen;
        string tag;
        tag = $sformatf("command %0d fire", n);
        fire_board  = board_sel_t'(cmd_board[n]);
        fire_row    = coord_t'(cmd_row[n]);
        fire_col    = coord_t'(cmd_col[n]);
        fire_strobe = 1'b1;
        @(posedge clk);
        #1;
        fire_strobe = 1'b0;
        check_busy(fire_busy, 1'b1, {tag, " fire_busy"});
        wait_fire(seen);
        if (seen) begin
            check_result(fire_result, shot_result_e'(cmd_exp[n][1:0]), tag);
            compare_counters(n, tag);       // Hit count drops with the done pulse
            @(posedge clk);
            #1;
            check_busy(fire_busy, 1'b0, {tag, " fire_busy"});
        end
    endtask

    initial begin
        rst            = 1'b0;
        place_strobe   = 1'b0;
        place_board    = 1'b0;
        place_row      = '0;
        place_col      = '0;
        place_vertical = 1'b0;
        place_len      = '0;
        fire_strobe    = 1'b0;
        fire_board     = 1'b0;
        fire_row       = '0;
        fire_col       = '0;
        exp_ships[0]   = '0;
        exp_ships[1]   = '0;
        for (int i = 0; i < 10; i++) begin
            far_marked[i] = 1'b0;
        end
        load_commands();
        loaded = 1'b1;                      // Starts the watchdog
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        for (int n = 0; n < num_cmds; n++) begin
            @(posedge clk);
            #1;
            if (cmd_op[n] == "P") run_place(n);
            else run_fire(n);
        end
        @(posedge clk);
        $display("Errors: %0d wrong value, %0d missing completion, %0d data file",
                 value_errors, timeout_errors, file_errors);
        if (value_errors + timeout_errors + file_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Budget grows with the number of commands
    initial begin
        wait (loaded);
        repeat (num_cmds * cycles_per_cmd + 20) @(posedge clk);
        $display("Watchdog expired, the run did not end within its cycle budget");
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- bench/naval_testdata.txt
# op board row col vertical length expect left0 left1
# expect is place_ok for P, and 0 miss, 1 hit, 2 repeat for F
F 0 4 4 0 0 0 0 0
F 0 4 4 0 0 2 0 0
F 1 0 0 0 0 0 0 0
P 0 0 0 0 3 1 3 0
P 0 1 4 1 3 1 6 0
P 0 0 3 0 3 0 6 0
P 0 3 0 1 3 0 6 0
P 0 0 1 1 2 0 6 0
P 0 2 0 1 1 1 7 0
P 0 4 0 0 2 0 7 0
P 1 0 1 0 2 1 7 2
P 1 1 0 0 3 1 7 5
F 0 0 0 0 0 1 6 5
F 0 0 0 0 0 2 6 5
F 0 0 1 0 0 1 5 5
F 0 0 2 0 0 1 4 5
F 0 1 4 0 0 1 3 5
F 0 2 4 0 0 1 2 5
F 0 2 2 0 0 0 2 5
F 0 3 4 0 0 1 1 5
F 0 2 0 0 0 1 0 5
F 0 2 0 0 0 2 0 5
F 1 0 1 0 0 1 0 4
P 1 0 1 1 2 0 0 4
P 1 2 2 0 3 1 0 7

//--- logic/board_arbiter.sv
`timescale 1ns/100ps

module board_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  place_req,
    input  logic                  place_we,
    input  naval_pkg::cell_addr_t place_addr,
    input  naval_pkg::cell_t      place_wdata,
    input  logic                  shot_req,
    input  logic                  shot_we,
    input  naval_pkg::cell_addr_t shot_addr,
    input  naval_pkg::cell_t      shot_wdata,
    output logic                  place_gnt,
    output logic                  shot_gnt,
    output naval_pkg::cell_addr_t mem_addr,
    output logic                  mem_we,
    output naval_pkg::cell_t      mem_wdata
);
    import naval_pkg::*;

    logic last_place;               // Placer held the most recent grant

    // Round robin, a lone requester always wins
    always_comb begin
        if (place_req && shot_req) begin
            place_gnt = !last_place;    // Placer first after reset
            shot_gnt  = last_place;
        end else begin
            place_gnt = place_req;
            shot_gnt  = shot_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            last_place <= 1'b0;
        end else if (place_gnt || shot_gnt) begin
            last_place <= place_gnt;    // Remember who went last
        end
    end

    // Memory follows the granted engine
    always_comb begin
        mem_addr  = '0;                 // Idle port parks on cell 0
        mem_we    = 1'b0;
        mem_wdata = cell_water;
        if (place_gnt) begin
            mem_addr  = place_addr;
            mem_we    = place_we;
            mem_wdata = place_wdata;
        end else if (shot_gnt) begin
            mem_addr  = shot_addr;
            mem_we    = shot_we;
            mem_wdata = shot_wdata;
        end
    end

    // A requester that loses one cycle wins the next
    a_place_served: assert property (
        @(posedge clk) disable iff (!rst)
        place_req && !place_gnt |=> place_gnt || !place_req
    ) else $error("placer passed over twice in a row");

    a_shot_served: assert property (
        @(posedge clk) disable iff (!rst)
        shot_req && !shot_gnt |=> shot_gnt || !shot_req
    ) else $error("resolver passed over twice in a row");

endmodule

//--- logic/board_ram.sv
`timescale 1ns/100ps

module board_ram (
    input  logic                  clk,
    input  logic                  rst,
    input  naval_pkg::cell_addr_t waddr,
    input  naval_pkg::cell_addr_t raddr,
    input  logic                  we,
    input  naval_pkg::cell_t      wdata,
    output naval_pkg::cell_t      rdata
);
    import naval_pkg::*;

    cell_t cells [num_cells];       // Board 0 at 0..24, board 1 at 25..49

    // Write port, whole array back to water on reset
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < num_cells; i++) begin
                cells[i] <= cell_water;
            end
        end else if (we) begin
            cells[waddr] <= wdata;
        end
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rdata <= cells[raddr];      // Same-address write shows up a cycle later
    end

    // Engines must only ever present cells that exist on a board
    a_addr_in_range: assert property (
        @(posedge clk) disable iff (!rst)
        (raddr < num_cells) && (!we || (waddr < num_cells))
    ) else $error("board_ram access outside the boards");

endmodule

//--- logic/naval_pkg.sv
package naval_pkg;

    // Board geometry
    localparam int board_dim       = 5;                       // Rows and columns per board
    localparam int num_boards      = 2;                       // Player and opponent
    localparam int cells_per_board = board_dim * board_dim;
    localparam int num_cells       = num_boards * cells_per_board;

    // Fleet limits per board
    localparam int max_ships       = 3;
    localparam int max_ship_len    = 3;

    typedef logic [2:0] coord_t;        // Row or column index
    typedef logic [5:0] cell_addr_t;    // board*25 + row*5 + col
    typedef logic       board_sel_t;    // 0 player, 1 opponent
    typedef logic [1:0] ship_len_t;     // 1 to 3
    typedef logic [1:0] cell_t;         // Raw cell code as stored
    typedef logic [3:0] hits_cnt_t;     // Ship cells still standing, 9 at most

    // What a cell holds
    typedef enum logic [1:0] {
        cell_water = 2'd0,
        cell_ship  = 2'd1,
        cell_miss  = 2'd2,
        cell_hit   = 2'd3
    } cell_code_e;

    // Outcome of one shot
    typedef enum logic [1:0] {
        shot_miss   = 2'd0,
        shot_hit    = 2'd1,
        shot_repeat = 2'd2              // Cell was already a miss or a hit
    } shot_result_e;

    // Flat memory address of one cell
    function automatic cell_addr_t cell_addr(
        input board_sel_t board,
        input coord_t     row,
        input coord_t     col
    );
        cell_addr_t base;
        base = board ? cell_addr_t'(cells_per_board) : cell_addr_t'(0);
        return base + cell_addr_t'(row) * cell_addr_t'(board_dim) + cell_addr_t'(col);
    endfunction

endpackage

//--- logic/naval_top.sv
`timescale 1ns/100ps

module naval_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    place_strobe,
    input  naval_pkg::board_sel_t   place_board,
    input  naval_pkg::coord_t       place_row,
    input  naval_pkg::coord_t       place_col,
    input  logic                    place_vertical,
    input  naval_pkg::ship_len_t    place_len,
    output logic                    place_busy,
    output logic                    place_done,
    output logic                    place_ok,
    output logic [1:0]              ships_placed_0,
    output logic [1:0]              ships_placed_1,
    input  logic                    fire_strobe,
    input  naval_pkg::board_sel_t   fire_board,
    input  naval_pkg::coord_t       fire_row,
    input  naval_pkg::coord_t       fire_col,
    output logic                    fire_busy,
    output logic                    fire_done,
    output naval_pkg::shot_result_e fire_result,
    output naval_pkg::hits_cnt_t    cells_left_0,
    output naval_pkg::hits_cnt_t    cells_left_1,
    output logic                    fleet_sunk_0,
    output logic                    fleet_sunk_1
);
    import naval_pkg::*;

    logic       place_req, place_we, place_gnt;     // Placer side of the arbiter
    cell_addr_t place_addr;
    cell_t      place_wdata;
    logic       shot_req, shot_we, shot_gnt;        // Resolver side
    cell_addr_t shot_addr;
    cell_t      shot_wdata;
    cell_addr_t mem_addr;                           // Shared memory port
    logic       mem_we;
    cell_t      mem_wdata, mem_rdata;
    ship_len_t  placed_len;                         // Placer to resolver
    board_sel_t placed_board;

    ship_placer u_placer (
        .clk, .rst, .place_strobe, .place_board, .place_row, .place_col,
        .place_vertical, .place_len,
        .gnt(place_gnt), .rdata(mem_rdata),
        .req(place_req), .we(place_we), .addr(place_addr), .wdata(place_wdata),
        .place_busy, .place_done, .place_ok, .ships_placed_0, .ships_placed_1,
        .placed_len, .placed_board
    );

    shot_resolver u_resolver (
        .clk, .rst, .fire_strobe, .fire_board, .fire_row, .fire_col,
        .ship_added(place_done && place_ok),        // Successful placement only
        .placed_len, .placed_board,
        .gnt(shot_gnt), .rdata(mem_rdata),
        .req(shot_req), .we(shot_we), .addr(shot_addr), .wdata(shot_wdata),
        .fire_busy, .fire_done, .fire_result,
        .cells_left_0, .cells_left_1, .fleet_sunk_0, .fleet_sunk_1
    );

    board_arbiter u_arbiter (
        .clk, .rst,
        .place_req, .place_we, .place_addr, .place_wdata,
        .shot_req, .shot_we, .shot_addr, .shot_wdata,
        .place_gnt, .shot_gnt, .mem_addr, .mem_we, .mem_wdata
    );

    board_ram u_ram (
        .clk, .rst,
        .waddr(mem_addr), .raddr(mem_addr),         // One address serves both ports
        .we(mem_we), .wdata(mem_wdata), .rdata(mem_rdata)
    );

endmodule

//--- logic/ship_placer.sv
`timescale 1ns/100ps

module ship_placer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  place_strobe,
    input  naval_pkg::board_sel_t place_board,
    input  naval_pkg::coord_t     place_row,
    input  naval_pkg::coord_t     place_col,
    input  logic                  place_vertical,
    input  naval_pkg::ship_len_t  place_len,
    input  logic                  gnt,
    input  naval_pkg::cell_t      rdata,
    output logic                  req,
    output logic                  we,
    output naval_pkg::cell_addr_t addr,
    output naval_pkg::cell_t      wdata,
    output logic                  place_busy,
    output logic                  place_done,
    output logic                  place_ok,
    output logic [1:0]            ships_placed_0,
    output logic [1:0]            ships_placed_1,
    output naval_pkg::ship_len_t  placed_len,
    output naval_pkg::board_sel_t placed_board
);
    import naval_pkg::*;

    typedef enum logic [2:0] {
        st_idle, st_check, st_read, st_wait_data, st_write, st_finish
    } state_e;

    state_e     state;
    board_sel_t board_q;            // Latched command
    coord_t     row_q;
    coord_t     col_q;
    logic       vert_q;
    ship_len_t  len_q;
    logic [1:0] idx;                // Ship cell being visited
    logic       ok_q;
    coord_t     cur_row;
    coord_t     cur_col;
    logic [3:0] end_pos;            // Last cell along the ship axis
    logic       in_bounds;
    logic       fleet_full;
    logic       last_cell;

    // Vertical ships walk down a column
    assign cur_row    = vert_q ? row_q + coord_t'(idx) : row_q;
    assign cur_col    = vert_q ? col_q : col_q + coord_t'(idx);
    assign end_pos    = (vert_q ? {1'b0, row_q} : {1'b0, col_q}) + {2'b00, len_q} - 4'd1;
    assign in_bounds  = (len_q != '0) && (len_q <= max_ship_len) && (row_q < board_dim)
                        && (col_q < board_dim) && (end_pos < board_dim);
    assign fleet_full = board_q ? (ships_placed_1 == max_ships) : (ships_placed_0 == max_ships);
    assign last_cell  = (idx == len_q - 2'd1);

    assign addr         = cell_addr(board_q, cur_row, cur_col);
    assign req          = (state == st_read) || (state == st_write);
    assign we           = (state == st_write);
    assign wdata        = cell_ship;
    assign place_busy   = (state != st_idle);
    assign place_done   = (state == st_finish);     // One cycle in finish
    assign place_ok     = ok_q;
    assign placed_len   = len_q;
    assign placed_board = board_q;

    always_ff @(posedge clk) begin
        if (state == st_idle && place_strobe) begin
            board_q <= place_board;
            row_q   <= place_row;
            col_q   <= place_col;
            vert_q  <= place_vertical;
            len_q   <= place_len;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state          <= st_idle;
            idx            <= '0;
            ok_q           <= 1'b0;
            ships_placed_0 <= '0;
            ships_placed_1 <= '0;
        end else begin
            case (state)
                st_idle: if (place_strobe) begin     // Strobes while busy are dropped
                    idx   <= '0;
                    ok_q  <= 1'b0;
                    state <= st_check;
                end
                st_check: state <= (in_bounds && !fleet_full) ? st_read : st_finish;
                st_read: if (gnt) state <= st_wait_data;
                st_wait_data: begin
                    if (rdata != cell_water) begin
                        state <= st_finish;          // Overlap, nothing written
                    end else if (last_cell) begin
                        idx   <= '0;
                        state <= st_write;
                    end else begin
                        idx   <= idx + 2'd1;
                        state <= st_read;
                    end
                end
                st_write: if (gnt) begin
                    if (last_cell) begin
                        ok_q  <= 1'b1;
                        state <= st_finish;
                        if (board_q) ships_placed_1 <= ships_placed_1 + 2'd1;
                        else         ships_placed_0 <= ships_placed_0 + 2'd1;
                    end else begin
                        idx <= idx + 2'd1;
                    end
                end
                default: state <= st_idle;           // Finish
            endcase
        end
    end

    // A waiting request keeps its cell until the arbiter lets it through
    a_hold_request: assert property (
        @(posedge clk) disable iff (!rst)
        req && !gnt |=> req && $stable(addr) && $stable(we)
    ) else $error("placer changed its request while waiting");

endmodule

//--- logic/shot_resolver.sv
`timescale 1ns/100ps

module shot_resolver (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fire_strobe,
    input  naval_pkg::board_sel_t   fire_board,
    input  naval_pkg::coord_t       fire_row,
    input  naval_pkg::coord_t       fire_col,
    input  logic                    ship_added,
    input  naval_pkg::ship_len_t    placed_len,
    input  naval_pkg::board_sel_t   placed_board,
    input  logic                    gnt,
    input  naval_pkg::cell_t        rdata,
    output logic                    req,
    output logic                    we,
    output naval_pkg::cell_addr_t   addr,
    output naval_pkg::cell_t        wdata,
    output logic                    fire_busy,
    output logic                    fire_done,
    output naval_pkg::shot_result_e fire_result,
    output naval_pkg::hits_cnt_t    cells_left_0,
    output naval_pkg::hits_cnt_t    cells_left_1,
    output logic                    fleet_sunk_0,
    output logic                    fleet_sunk_1
);
    import naval_pkg::*;

    typedef enum logic [2:0] {st_idle, st_read, st_wait_data, st_write, st_finish} state_e;

    state_e     state;
    board_sel_t board_q;            // Target latched at the strobe
    coord_t     row_q;
    coord_t     col_q;
    logic       write_q;            // Target needs a mark
    cell_t      mark_q;
    logic       armed_0;            // Board has had a ship placed
    logic       armed_1;
    logic       add_0;
    logic       add_1;
    logic       dec_0;
    logic       dec_1;

    assign addr      = cell_addr(board_q, row_q, col_q);
    assign req       = (state == st_read) || (state == st_write && write_q);
    assign we        = (state == st_write) && write_q;
    assign wdata     = mark_q;
    assign fire_busy = (state != st_idle);
    assign fire_done = (state == st_finish);

    // Ship growth from the placer, hit loss when the mark lands
    assign add_0 = ship_added && (placed_board == 1'b0);
    assign add_1 = ship_added && (placed_board == 1'b1);
    assign dec_0 = (state == st_write) && gnt && (fire_result == shot_hit) && !board_q;
    assign dec_1 = (state == st_write) && gnt && (fire_result == shot_hit) && board_q;

    assign fleet_sunk_0 = armed_0 && (cells_left_0 == '0);
    assign fleet_sunk_1 = armed_1 && (cells_left_1 == '0);

    always_ff @(posedge clk) begin
        if (state == st_idle && fire_strobe) begin
            board_q <= fire_board;
            row_q   <= fire_row;
            col_q   <= fire_col;
        end
        if (state == st_wait_data) begin
            mark_q <= (rdata == cell_ship) ? cell_hit : cell_miss;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state        <= st_idle;
            write_q      <= 1'b0;
            fire_result  <= shot_miss;
            cells_left_0 <= '0;
            cells_left_1 <= '0;
            armed_0      <= 1'b0;
            armed_1      <= 1'b0;
        end else begin
            case (state)
                st_idle:  if (fire_strobe) state <= st_read;
                st_read:  if (gnt) state <= st_wait_data;
                st_wait_data: begin                  // Cell code arrives now
                    write_q     <= (rdata == cell_water) || (rdata == cell_ship);
                    fire_result <= (rdata == cell_water) ? shot_miss :
                                   (rdata == cell_ship)  ? shot_hit  : shot_repeat;
                    state       <= st_write;
                end
                st_write: if (gnt || !write_q) state <= st_finish;  // Repeat skips the write
                default:  state <= st_idle;
            endcase
            armed_0      <= armed_0 || add_0;
            armed_1      <= armed_1 || add_1;
            cells_left_0 <= cells_left_0 + (add_0 ? hits_cnt_t'(placed_len) : hits_cnt_t'(0))
                            - (dec_0 ? hits_cnt_t'(1) : hits_cnt_t'(0));
            cells_left_1 <= cells_left_1 + (add_1 ? hits_cnt_t'(placed_len) : hits_cnt_t'(0))
                            - (dec_1 ? hits_cnt_t'(1) : hits_cnt_t'(0));
        end
    end

    // A board with no ship cells left stays empty until the placer adds one
    a_left0_floor: assert property (
        @(posedge clk) disable iff (!rst)
        (cells_left_0 == '0) && !add_0 |=> (cells_left_0 == '0)
    ) else $error("cells_left_0 dropped below zero");

    a_left1_floor: assert property (
        @(posedge clk) disable iff (!rst)
        (cells_left_1 == '0) && !add_1 |=> (cells_left_1 == '0)
    ) else $error("cells_left_1 dropped below zero");

endmodule

//--- naval.f
logic/naval_pkg.sv
logic/board_ram.sv
logic/board_arbiter.sv
logic/ship_placer.sv
logic/shot_resolver.sv
logic/naval_top.sv
bench/naval_tb.sv
